// ==== rtl/flip_ctrl_fsm.sv ====
/* run sequencer of the flip stage
   prefetches icon 0, enables the engine and ends the run at the terminal count */
`timescale 1ns/100ps
`default_nettype none

module flip_ctrl_fsm (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic start_i,
    input wire logic terminal_i,
    input wire logic icon_wrap_i,
    output logic en_o,
    output logic prefetch_o,
    output logic clear_o,
    output logic busy_o,
    output logic done_o,
    output logic wrapped_o
);

    flip_pkg::run_state_e state_q;
    flip_pkg::run_state_e state_d;
    logic start_ok;
    logic wrapped_q;

    // a start only counts while no run is in flight
    assign start_ok = start_i &&
                      ((state_q == flip_pkg::IDLE) || (state_q == flip_pkg::DONE));

    always_comb begin
        state_d = state_q;
        case (state_q)
            flip_pkg::IDLE: begin
                if (start_ok) state_d = flip_pkg::PREFETCH;
            end
            // single cycle, icon 0 lands by the first RUN cycle
            flip_pkg::PREFETCH: state_d = flip_pkg::RUN;
            flip_pkg::RUN: begin
                if (terminal_i) state_d = flip_pkg::DONE;
            end
            flip_pkg::DONE: begin
                if (start_ok) state_d = flip_pkg::PREFETCH;
            end
            default: state_d = flip_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= flip_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // wrap flag is sticky for the whole run, cleared by the next start
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wrapped_q <= 1'b0;
        end else if (start_ok) begin
            wrapped_q <= 1'b0;
        end else if (icon_wrap_i) begin
            wrapped_q <= 1'b1;
        end
    end

    // drop enable with the terminal count so no extra spin slips in
    assign en_o = (state_q == flip_pkg::RUN) && !terminal_i;
    assign prefetch_o = (state_q == flip_pkg::PREFETCH);
    assign clear_o = start_ok;
    assign busy_o = (state_q == flip_pkg::PREFETCH) || (state_q == flip_pkg::RUN);
    assign done_o = (state_q == flip_pkg::DONE);
    assign wrapped_o = wrapped_q;

endmodule

`default_nettype wire

// ==== rtl/flip_defs.svh ====
/* sizing and register map of the spin-flip stage
   include wherever a width, depth or word address is needed */
`ifndef FLIP_DEFS_SVH
`define FLIP_DEFS_SVH

// one spin vector and one icon share a wishbone word
`define FLIP_DATASPIN 32

// icon memory geometry
`define FLIP_ICON_DEPTH 64
`define FLIP_ICON_AW 6

// spins per run
`define FLIP_CNT_W 16

// control and status word addresses
`define FLIP_REG_CTRL 0
`define FLIP_REG_LAST 1
`define FLIP_REG_COUNT 2
`define FLIP_REG_STATUS 3

// icon window starts here, its address bit selects icon writes
`define FLIP_ICON_BASE 64

`endif

// ==== rtl/flip_engine.sv ====
/* xors each accepted spin with the current flip icon
   and walks the icon memory through the programmed icon count */
`timescale 1ns/100ps
`default_nettype none

module flip_engine (
    input wire logic clk_i,
    input wire logic arst_n_i,

    // sequencing from the run fsm
    input wire logic en_i,
    input wire logic prefetch_i,
    input wire logic clear_i,
    input wire flip_pkg::run_cfg_t cfg_i,

    // upstream spin stream
    input wire logic prev_spin_valid_i,
    input wire flip_pkg::spin_t prev_spin_i,
    output logic prev_spin_ready_o,

    // downstream flipped stream
    input wire logic flipped_spin_ready_i,
    output flip_pkg::spin_t flipped_spin_o,
    output logic flipped_spin_valid_o,

    // icon memory read port
    output logic icon_ren_o,
    output flip_pkg::icon_addr_t icon_raddr_o,
    input wire flip_pkg::spin_t icon_rdata_i,

    output logic icon_wrap_o
);

    logic in_hs;
    logic bypass;
    logic ren;
    logic at_last;
    flip_pkg::icon_len_t last_idx;
    flip_pkg::icon_addr_t raddr_q;
    flip_pkg::icon_addr_t raddr_next;

    // back-pressure passes straight through, only while enabled
    assign prev_spin_ready_o = en_i & flipped_spin_ready_i;
    assign flipped_spin_valid_o = en_i & prev_spin_valid_i;
    assign in_hs = prev_spin_valid_i & prev_spin_ready_o;

    // bypass forwards spins and stops all icon traffic
    assign bypass = cfg_i.flip_disable;

    // prefetch reads icon 0, every handshake reads the icon for the next spin
    assign ren = (prefetch_i | in_hs) & ~bypass;

    // wrap after the last programmed icon
    assign last_idx = cfg_i.icon_len - 1'b1;
    assign at_last = ({1'b0, raddr_q} == last_idx);
    assign raddr_next = at_last ? '0 : flip_pkg::icon_addr_t'(raddr_q + 1'b1);

    assign icon_ren_o = ren;
    assign icon_raddr_o = raddr_q;
    assign icon_wrap_o = ren & at_last;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            raddr_q <= '0;
        end else if (clear_i) begin
            raddr_q <= '0;
        end else if (ren) begin
            raddr_q <= raddr_next;
        end
    end

    // zero latency flip with the icon held on the memory read port
    assign flipped_spin_o = bypass ? prev_spin_i : (prev_spin_i ^ icon_rdata_i);

endmodule

`default_nettype wire

// ==== rtl/flip_icon_mem.sv ====
/* flip icon storage, written from the host port
   and read by the engine with one cycle of latency */
`timescale 1ns/100ps
`default_nettype none

`include "flip_defs.svh"

module flip_icon_mem (
    input wire logic clk_i,
    input wire logic arst_n_i,

    // host side write request
    input wire flip_pkg::icon_wr_t wr_i,

    // engine side read port
    input wire logic ren_i,
    input wire flip_pkg::icon_addr_t raddr_i,
    output flip_pkg::spin_t rdata_o
);

    // icon array, contents only defined once the host loads them
    flip_pkg::spin_t mem [`FLIP_ICON_DEPTH];

    // write port
    always_ff @(posedge clk_i) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // registered read
    // word stays on rdata_o until the next read enable
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (ren_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/flip_pkg.sv ====
/* shared types of the spin-flip stage
   referenced by scoped name from every block */
`default_nettype none

`include "flip_defs.svh"

package flip_pkg;

    // vectors with a meaning of their own
    typedef logic [`FLIP_DATASPIN-1:0] spin_t;
    typedef logic [`FLIP_ICON_AW-1:0] icon_addr_t;
    // icon count runs 1..64 so it needs one bit more than the address
    typedef logic [`FLIP_ICON_AW:0] icon_len_t;
    typedef logic [`FLIP_CNT_W-1:0] spin_cnt_t;

    // write request into the icon memory
    typedef struct packed {
        logic we;
        icon_addr_t addr;
        spin_t data;
    } icon_wr_t;

    // run configuration held by the host registers
    typedef struct packed {
        logic flip_disable;
        icon_len_t icon_len;
        spin_cnt_t spin_cnt;
    } run_cfg_t;

    typedef enum logic [1:0] {IDLE, PREFETCH, RUN, DONE} run_state_e;

endpackage

`default_nettype wire

// ==== rtl/flip_top.sv ====
/* spin-flip stage of the annealer, host registers on wishbone classic
   and a zero-latency valid/ready spin path */
`timescale 1ns/100ps
`default_nettype none

`include "flip_defs.svh"

module flip_top (
    input wire logic clk_i,
    input wire logic arst_n_i,

    // host port
    input wire logic wb_cyc_i,
    input wire logic wb_stb_i,
    input wire logic wb_we_i,
    input wire logic [`FLIP_ICON_AW:0] wb_adr_i,
    input wire flip_pkg::spin_t wb_dat_i,
    input wire logic [3:0] wb_sel_i,
    output logic wb_ack_o,
    output flip_pkg::spin_t wb_dat_o,

    // spin streams
    input wire logic prev_spin_valid_i,
    input wire flip_pkg::spin_t prev_spin_i,
    output logic prev_spin_ready_o,
    input wire logic flipped_spin_ready_i,
    output flip_pkg::spin_t flipped_spin_o,
    output logic flipped_spin_valid_o
);

    flip_pkg::icon_wr_t icon_wr;
    flip_pkg::run_cfg_t cfg;
    flip_pkg::icon_addr_t icon_raddr;
    flip_pkg::spin_t icon_rdata;
    logic start;
    logic busy;
    logic done;
    logic wrapped;
    logic en;
    logic prefetch;
    logic clear;
    logic terminal;
    logic icon_wrap;
    logic icon_ren;
    logic out_hs;

    // counted on the downstream side
    assign out_hs = flipped_spin_valid_o & flipped_spin_ready_i;

    flip_wb_regs regs_i (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_sel_i(wb_sel_i),
        .wb_ack_o(wb_ack_o),
        .wb_dat_o(wb_dat_o),
        .icon_wr_o(icon_wr),
        .cfg_o(cfg),
        .start_o(start),
        .busy_i(busy),
        .done_i(done),
        .wrapped_i(wrapped)
    );

    flip_ctrl_fsm fsm_i (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .start_i(start),
        .terminal_i(terminal),
        .icon_wrap_i(icon_wrap),
        .en_o(en),
        .prefetch_o(prefetch),
        .clear_o(clear),
        .busy_o(busy),
        .done_o(done),
        .wrapped_o(wrapped)
    );

    // only the terminal flag steers the run
    spin_counter counter_i (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .clear_i(clear),
        .step_i(out_hs),
        .limit_i(cfg.spin_cnt),
        .count_o(),
        .terminal_o(terminal)
    );

    flip_engine engine_i (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .en_i(en),
        .prefetch_i(prefetch),
        .clear_i(clear),
        .cfg_i(cfg),
        .prev_spin_valid_i(prev_spin_valid_i),
        .prev_spin_i(prev_spin_i),
        .prev_spin_ready_o(prev_spin_ready_o),
        .flipped_spin_ready_i(flipped_spin_ready_i),
        .flipped_spin_o(flipped_spin_o),
        .flipped_spin_valid_o(flipped_spin_valid_o),
        .icon_ren_o(icon_ren),
        .icon_raddr_o(icon_raddr),
        .icon_rdata_i(icon_rdata),
        .icon_wrap_o(icon_wrap)
    );

    flip_icon_mem mem_i (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .wr_i(icon_wr),
        .ren_i(icon_ren),
        .raddr_i(icon_raddr),
        .rdata_o(icon_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/flip_wb_regs.sv ====
/* wishbone classic slave of the flip stage
   holds the run configuration, reports status and steers icon writes */
`timescale 1ns/100ps
`default_nettype none

`include "flip_defs.svh"

module flip_wb_regs (
    input wire logic clk_i,
    input wire logic arst_n_i,

    // wishbone classic slave, word addressed
    input wire logic wb_cyc_i,
    input wire logic wb_stb_i,
    input wire logic wb_we_i,
    input wire logic [`FLIP_ICON_AW:0] wb_adr_i,
    input wire flip_pkg::spin_t wb_dat_i,
    input wire logic [3:0] wb_sel_i,
    output logic wb_ack_o,
    output flip_pkg::spin_t wb_dat_o,

    output flip_pkg::icon_wr_t icon_wr_o,
    output flip_pkg::run_cfg_t cfg_o,
    output logic start_o,

    // status from the run fsm
    input wire logic busy_i,
    input wire logic done_i,
    input wire logic wrapped_i
);

    logic req;
    logic req_q;
    logic fire;
    logic wr;
    logic icon_win;
    flip_pkg::spin_t rd_word;

    // ack only on the first cycle a request is seen
    assign req = wb_cyc_i & wb_stb_i;
    assign fire = req & ~req_q;
    assign wr = fire & wb_we_i;
    assign icon_win = (wb_adr_i >= `FLIP_ICON_BASE);

    // icons go in as whole words
    assign icon_wr_o.we = wr & icon_win & (&wb_sel_i);
    assign icon_wr_o.addr = wb_adr_i[`FLIP_ICON_AW-1:0];
    assign icon_wr_o.data = wb_dat_i;

    always_comb begin
        rd_word = '0;
        if (!icon_win) begin
            case (wb_adr_i)
                `FLIP_REG_CTRL: rd_word[1] = cfg_o.flip_disable;
                `FLIP_REG_LAST: rd_word[`FLIP_ICON_AW:0] = cfg_o.icon_len;
                `FLIP_REG_COUNT: rd_word[`FLIP_CNT_W-1:0] = cfg_o.spin_cnt;
                `FLIP_REG_STATUS: rd_word[2:0] = {wrapped_i, done_i, busy_i};
                default: rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= 1'b0;
            wb_ack_o <= 1'b0;
            start_o <= 1'b0;
            // full icon window until the host programs a count
            cfg_o.flip_disable <= 1'b0;
            cfg_o.icon_len <= `FLIP_ICON_DEPTH;
            cfg_o.spin_cnt <= '0;
        end else begin
            req_q <= req;
            wb_ack_o <= fire;
            // start pulses one cycle after the CTRL write
            start_o <= wr && !icon_win && (wb_adr_i == `FLIP_REG_CTRL) &&
                       wb_sel_i[0] && wb_dat_i[0];
            if (wr && !icon_win) begin
                case (wb_adr_i)
                    `FLIP_REG_CTRL: begin
                        if (wb_sel_i[0]) cfg_o.flip_disable <= wb_dat_i[1];
                    end
                    `FLIP_REG_LAST: begin
                        if (wb_sel_i[0]) cfg_o.icon_len <= wb_dat_i[`FLIP_ICON_AW:0];
                    end
                    `FLIP_REG_COUNT: begin
                        if (wb_sel_i[0]) cfg_o.spin_cnt[7:0] <= wb_dat_i[7:0];
                        if (wb_sel_i[1]) cfg_o.spin_cnt[15:8] <= wb_dat_i[15:8];
                    end
                    default: ;
                endcase
            end
        end
    end

    // read word captured with the ack
    always_ff @(posedge clk_i) begin
        if (fire) begin
            wb_dat_o <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/spin_counter.sv ====
/* counts flipped spins taken downstream during a run
   and flags the programmed terminal count */
`timescale 1ns/100ps
`default_nettype none

module spin_counter (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic clear_i,
    // one output handshake
    input wire logic step_i,
    input wire flip_pkg::spin_cnt_t limit_i,
    output flip_pkg::spin_cnt_t count_o,
    output logic terminal_o
);

    flip_pkg::spin_cnt_t count_q;

    // terminal as soon as the limit is reached, a zero limit ends at once
    assign terminal_o = (count_q == limit_i);
    assign count_o = count_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (step_i && !terminal_o) begin
            // saturate at the limit
            count_q <= count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the spin-flip testbench with verilator and run it
# the exit status of the simulation is the result of the run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module flip_tb -o flip_sim &&
./obj_dir/flip_sim || exit 1

// ==== test/flip_tb.sv ====
/* testbench of the spin-flip stage, loads icons over wishbone and streams
   lfsr spins through four runs, checked against a reference model */
`timescale 1ns/100ps
`default_nettype none

`include "flip_defs.svh"

module flip_tb;

    // loop limit for every wait, in cycles or bus accesses
    localparam int TIMEOUT = 2000;

    logic clk;
    logic arst_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [`FLIP_ICON_AW:0] wb_adr;
    flip_pkg::spin_t wb_dat_w;
    logic [3:0] wb_sel;
    logic wb_ack;
    flip_pkg::spin_t wb_dat_r;
    logic spin_valid;
    flip_pkg::spin_t spin_in;
    logic spin_ready;
    logic out_ready;
    flip_pkg::spin_t spin_out;
    logic out_valid;

    // model state, icon copy and the spins of the current run
    logic [31:0] lfsr;
    flip_pkg::spin_t icons [`FLIP_ICON_DEPTH];
    flip_pkg::spin_t spins [$];
    int icon_cnt;
    int run_len;
    bit bypass;
    int in_idx;
    int out_idx;

    flip_top flip_top_i (
        .clk_i(clk),
        .arst_n_i(arst_n),
        .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb),
        .wb_we_i(wb_we),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w),
        .wb_sel_i(wb_sel),
        .wb_ack_o(wb_ack),
        .wb_dat_o(wb_dat_r),
        .prev_spin_valid_i(spin_valid),
        .prev_spin_i(spin_in),
        .prev_spin_ready_o(spin_ready),
        .flipped_spin_ready_i(out_ready),
        .flipped_spin_o(spin_out),
        .flipped_spin_valid_o(out_valid)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic bit rand_bit();
        bit b;
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // spin k of a run is flipped by icon k mod count, bypass passes it as is
    function automatic flip_pkg::spin_t ref_flip(input flip_pkg::spin_t spin, input int k);
        if (bypass) begin
            return spin;
        end
        return spin ^ icons[k % icon_cnt];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // one classic cycle, ack sampled at the falling edge
    task automatic wb_access(input int adr, input bit we, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int t;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr[`FLIP_ICON_AW:0];
        wb_dat_w <= dat;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!wb_ack && t < TIMEOUT);
        assert (wb_ack) else fail_now("the wishbone ack never came");
        rdata = wb_dat_r;
        // strobe low for a cycle before the next access
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_write(input int adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(adr, 1'b1, dat, unused);
    endtask

    // full run, program, start, stream, then check the end state
    task automatic do_run(input int len, input int n, input bit byp, input bit gaps);
        logic [31:0] st;
        logic [31:0] exp_st;
        int t;
        bit acc;
        icon_cnt = len;
        run_len = n;
        bypass = byp;
        spins.delete();
        for (int i = 0; i < n; i++) begin
            spins.push_back(rand_bits(32));
        end
        wb_write(`FLIP_REG_LAST, len);
        wb_write(`FLIP_REG_COUNT, n);
        in_idx = 0;
        out_idx = 0;
        wb_write(`FLIP_REG_CTRL, {30'd0, byp, 1'b1});
        t = 0;
        acc = 1'b1;
        while (in_idx < n && t < TIMEOUT) begin
            @(posedge clk);
            // a pending spin holds until it is taken
            if (!spin_valid || acc) begin
                spin_valid <= gaps ? rand_bit() : 1'b1;
            end
            spin_in <= spins[in_idx];
            out_ready <= gaps ? rand_bit() : 1'b1;
            @(negedge clk);
            acc = spin_valid && spin_ready;
            if (acc) begin
                in_idx++;
            end
            t++;
        end
        assert (in_idx == n) else fail_now("the stage did not accept every spin of the run");
        // offer one more spin, the stage has to refuse it
        @(posedge clk);
        spin_valid <= 1'b1;
        spin_in <= rand_bits(32);
        out_ready <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            assert (!spin_ready) else fail_now("a spin was accepted after the run ended");
        end
        @(posedge clk);
        spin_valid <= 1'b0;
        t = 0;
        do begin
            wb_access(`FLIP_REG_STATUS, 1'b0, '0, st);
            t++;
        end while (!st[1] && t < TIMEOUT);
        assert (st[1]) else fail_now("the run never reached done");
        // reads touch the last icon once n reaches count - 1
        exp_st = {29'd0, (!byp && n >= len - 1), 1'b1, 1'b0};
        assert (st == exp_st)
        else fail_now($sformatf("FAILED at %0t: status %h expected %h", $time, st, exp_st));
        assert (out_idx == n)
        else fail_now($sformatf("FAILED at %0t: %0d outputs expected %0d", $time, out_idx, n));
    endtask

    // checker, zero latency so every output handshake is also an input one
    always @(negedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            assert (spin_valid && spin_ready)
            else fail_now($sformatf("FAILED at %0t: output without input handshake", $time));
            assert (out_idx < run_len)
            else fail_now($sformatf("FAILED at %0t: extra output spin %0d", $time, out_idx));
            assert (spin_out == ref_flip(spins[out_idx], out_idx))
            else fail_now($sformatf("FAILED at %0t: spin %0d got %h expected %h", $time,
                                    out_idx, spin_out, ref_flip(spins[out_idx], out_idx)));
            out_idx++;
        end
    end

    initial begin
        logic [31:0] st;
        clk = 1'b0;
        arst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = 4'hf;
        // stream offered from the start, an idle stage must still hold ready and valid low
        spin_valid = 1'b1;
        spin_in = '0;
        out_ready = 1'b1;
        lfsr = 32'hb474;
        icon_cnt = 1;
        run_len = 0;
        bypass = 1'b0;
        in_idx = 0;
        out_idx = 0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!wb_ack && !spin_ready && !out_valid)
        else fail_now("ack, ready or valid is high after reset");
        wb_access(`FLIP_REG_STATUS, 1'b0, '0, st);
        assert (st == '0)
        else fail_now($sformatf("FAILED at %0t: status %h after reset", $time, st));
        // every icon random, the model keeps its own copy
        for (int i = 0; i < `FLIP_ICON_DEPTH; i++) begin
            icons[i] = rand_bits(32);
            wb_write(`FLIP_ICON_BASE + i, icons[i]);
        end
        do_run(8, 20, 1'b0, 1'b0);
        do_run(8, 20, 1'b0, 1'b1);
        do_run(8, 20, 1'b1, 1'b1);
        // long icon window, never wraps and restarts at icon 0
        do_run(64, 10, 1'b0, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/flip_pkg.sv
rtl/flip_icon_mem.sv
rtl/flip_engine.sv
rtl/spin_counter.sv
rtl/flip_ctrl_fsm.sv
rtl/flip_wb_regs.sv
rtl/flip_top.sv
test/flip_tb.sv
